//--- hdl/sgd_params.svh
// sizing constants for the bit-weaved loss front end
`ifndef SGD_PARAMS_SVH
`define SGD_PARAMS_SVH

//////////////////////////////
// sample layout
//////////////////////////////

// features in one sample, one bit of each per plane
`define SGD_NUM_FEATURES 8
// bits per feature, same as planes per sample
`define SGD_FEATURE_BITS 4

//////////////////////////////
// datapath widths
//////////////////////////////

`define SGD_MODEL_WIDTH 16
// label, dot product and error share this width
`define SGD_LABEL_WIDTH 32
`define SGD_LABEL_FIFO_DEPTH 4

`endif

//--- hdl/sgd_pkg.sv
// shared vector types and handshake states for the loss front end
`include "sgd_params.svh"

package sgd_pkg;

    // one bit plane, bit j belongs to feature j
    typedef logic [`SGD_NUM_FEATURES-1:0] plane_t;

    // selects a feature or its model word
    typedef logic [$clog2(`SGD_NUM_FEATURES)-1:0] feat_idx_t;

    // signed model word x_j
    typedef logic signed [`SGD_MODEL_WIDTH-1:0] model_word_t;

    // dot product, label and error
    typedef logic signed [`SGD_LABEL_WIDTH-1:0] acc_t;

    // step shift, 0..31
    typedef logic [4:0] shift_t;

    // four-phase handshake phases
    typedef enum logic [1:0] {
        hs_idle,
        hs_hold,
        hs_release
    } hs_state_t;

endpackage

//--- hdl/sgd_dot_product.sv
// shift-and-add dot product of incoming bit planes against the model registers
`include "sgd_params.svh"

module sgd_dot_product (
    input  logic                 clk,
    input  logic                 rst_n_g,
    // plane handshake
    input  logic                 a_req,
    input  sgd_pkg::plane_t      a_plane,
    output logic                 a_ack,
    // model write port, idle only
    input  logic                 x_wr_en,
    input  sgd_pkg::feat_idx_t   x_wr_addr,
    input  sgd_pkg::model_word_t x_wr_data,
    output logic                 busy,
    // link to the loss unit
    output logic                 dot_valid,
    output sgd_pkg::acc_t        dot_value,
    input  logic                 dot_take
);

    import sgd_pkg::*;

    // model x, one word per feature
    model_word_t x_mem [`SGD_NUM_FEATURES];

    hs_state_t a_state;
    // which plane of the sample comes next, msb plane first
    logic [$clog2(`SGD_FEATURE_BITS)-1:0] plane_cnt;
    acc_t acc;
    acc_t plane_sum;
    acc_t acc_base;
    logic plane_latch;

    //////////////////////////////
    // model registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (x_wr_en)
        begin
            x_mem[x_wr_addr] <= x_wr_data;
        end
    end

    //////////////////////////////
    // plane datapath
    //////////////////////////////

    // sum of model words picked by the set bits of this plane
    always_comb
    begin
        plane_sum = '0;
        for (int j = 0; j < `SGD_NUM_FEATURES; j++)
        begin
            if (a_plane[j])
                plane_sum = plane_sum + acc_t'(x_mem[j]);
        end
    end

    // first plane starts from zero, later ones double the running value
    assign acc_base = (plane_cnt == '0) ? '0 : (acc <<< 1);

    // new plane only while no finished result is waiting
    assign plane_latch = (a_state == hs_idle) && a_req && !dot_valid;

    always_ff @(posedge clk)
    begin
        if (plane_latch)
            acc <= acc_base + plane_sum;
    end

    assign dot_value = acc;

    //////////////////////////////
    // handshake and sample control
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            a_state   <= hs_idle;
            a_ack     <= 1'b0;
            plane_cnt <= '0;
            busy      <= 1'b0;
            dot_valid <= 1'b0;
        end
        else
        begin
            case (a_state)
                hs_idle:
                begin
                    if (plane_latch)
                    begin
                        a_ack     <= 1'b1;
                        a_state   <= hs_hold;
                        plane_cnt <= plane_cnt + 1'b1;
                        busy      <= 1'b1;
                        // last plane done, counter wraps to zero
                        if (plane_cnt == (`SGD_FEATURE_BITS - 1))
                            dot_valid <= 1'b1;
                    end
                end
                hs_hold:
                begin
                    // sender dropped req, release ack
                    if (!a_req)
                    begin
                        a_ack   <= 1'b0;
                        a_state <= hs_idle;
                    end
                end
                default:
                begin
                    a_ack   <= 1'b0;
                    a_state <= hs_idle;
                end
            endcase

            // loss unit has paired the result
            if (dot_take)
            begin
                dot_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // model must not change under a sample in flight
    x_wr_idle_check: assert property (@(posedge clk) disable iff (!rst_n_g)
        !(x_wr_en && busy));

    // sender keeps the plane steady until it is acknowledged
    a_plane_stable_check: assert property (@(posedge clk) disable iff (!rst_n_g)
        (a_req && !a_ack) ##1 a_req |-> $stable(a_plane));

endmodule

//--- hdl/sgd_label_buffer.sv
// label fifo fed by a four-phase handshake and popped by the loss unit
`include "sgd_params.svh"

module sgd_label_buffer (
    input  logic          clk,
    input  logic          rst_n_g,
    // label handshake
    input  logic          b_req,
    input  sgd_pkg::acc_t b_label,
    output logic          b_ack,
    // head of fifo to the loss unit
    output logic          lbl_valid,
    output sgd_pkg::acc_t lbl_value,
    input  logic          lbl_take
);

    import sgd_pkg::*;

    acc_t fifo_mem [`SGD_LABEL_FIFO_DEPTH];
    logic [$clog2(`SGD_LABEL_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`SGD_LABEL_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`SGD_LABEL_FIFO_DEPTH+1)-1:0] count;
    hs_state_t b_state;
    logic full;
    logic push;

    assign full = (count == `SGD_LABEL_FIFO_DEPTH);
    // full fifo holds back the ack
    assign push = (b_state == hs_idle) && b_req && !full;

    // head straight out of the register array
    assign lbl_valid = (count != '0);
    assign lbl_value = fifo_mem[rd_ptr];

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= b_label;
    end

    //////////////////////////////
    // pointers and handshake
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            b_state <= hs_idle;
            b_ack   <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (lbl_take)
                rd_ptr <= rd_ptr + 1'b1;

            // push and pop together leave count as is
            if (push && !lbl_take)
                count <= count + 1'b1;
            else if (!push && lbl_take)
                count <= count - 1'b1;

            case (b_state)
                hs_idle:
                begin
                    if (push)
                    begin
                        b_ack   <= 1'b1;
                        b_state <= hs_hold;
                    end
                end
                hs_hold:
                begin
                    if (!b_req)
                    begin
                        b_ack   <= 1'b0;
                        b_state <= hs_idle;
                    end
                end
                default:
                begin
                    b_ack   <= 1'b0;
                    b_state <= hs_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // loss unit pops only what is there
    lbl_take_check: assert property (@(posedge clk) disable iff (!rst_n_g)
        lbl_take |-> lbl_valid);

    fifo_count_check: assert property (@(posedge clk) disable iff (!rst_n_g)
        count <= `SGD_LABEL_FIFO_DEPTH);

endmodule

//--- hdl/sgd_loss.sv
// pairs dot product with label and hands out the shifted error
`include "sgd_params.svh"

module sgd_loss (
    input  logic            clk,
    input  logic            rst_n_g,
    input  sgd_pkg::shift_t step_shift,
    // dot product link
    input  logic            dot_valid,
    input  sgd_pkg::acc_t   dot_value,
    output logic            dot_take,
    // label link
    input  logic            lbl_valid,
    input  sgd_pkg::acc_t   lbl_value,
    output logic            lbl_take,
    // result handshake
    output logic            res_req,
    output sgd_pkg::acc_t   res_error,
    input  logic            res_ack
);

    import sgd_pkg::*;

    hs_state_t res_state;
    acc_t diff;
    logic pair;

    //////////////////////////////
    // pairing
    //////////////////////////////

    // pair only when idle and both sides have data
    assign pair = (res_state == hs_idle) && dot_valid && lbl_valid;

    // both takes in the same cycle keeps samples and labels aligned
    assign dot_take = pair;
    assign lbl_take = pair;

    // signed a.x - b
    assign diff = dot_value - lbl_value;

    // arithmetic shift keeps the sign of negative errors
    always_ff @(posedge clk)
    begin
        if (pair)
            res_error <= diff >>> step_shift;
    end

    //////////////////////////////
    // result handshake
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            res_state <= hs_idle;
            res_req   <= 1'b0;
        end
        else
        begin
            case (res_state)
                hs_idle:
                begin
                    if (pair)
                    begin
                        res_req   <= 1'b1;
                        res_state <= hs_hold;
                    end
                end
                // req up, wait for the receiver's ack
                hs_hold:
                begin
                    if (res_ack)
                    begin
                        res_req   <= 1'b0;
                        res_state <= hs_release;
                    end
                end
                // req down, wait for ack to fall
                hs_release:
                begin
                    if (!res_ack)
                        res_state <= hs_idle;
                end
                default:
                begin
                    res_req   <= 1'b0;
                    res_state <= hs_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // receiver may sample the error any time req is up
    res_error_stable_check: assert property (@(posedge clk) disable iff (!rst_n_g)
        res_req ##1 res_req |-> $stable(res_error));

endmodule

//--- hdl/sgd_bw_loss_top.sv
// loss front end top, dot product and label buffer feeding the loss unit
`include "sgd_params.svh"

module sgd_bw_loss_top (
    input  logic                 clk,
    input  logic                 rst_n_g,
    // bit planes
    input  logic                 a_req,
    input  sgd_pkg::plane_t      a_plane,
    output logic                 a_ack,
    // labels
    input  logic                 b_req,
    input  sgd_pkg::acc_t        b_label,
    output logic                 b_ack,
    // model write
    input  logic                 x_wr_en,
    input  sgd_pkg::feat_idx_t   x_wr_addr,
    input  sgd_pkg::model_word_t x_wr_data,
    input  sgd_pkg::shift_t      step_shift,
    // results
    output logic                 res_req,
    output sgd_pkg::acc_t        res_error,
    input  logic                 res_ack
);

    import sgd_pkg::*;

    // dot product to loss
    logic dot_valid;
    acc_t dot_value;
    logic dot_take;

    // label fifo to loss
    logic lbl_valid;
    acc_t lbl_value;
    logic lbl_take;

    //////////////////////////////
    // sample and label paths
    //////////////////////////////

    sgd_dot_product sgd_dot_product_inst (
        .clk       (clk),
        .rst_n_g   (rst_n_g),
        .a_req     (a_req),
        .a_plane   (a_plane),
        .a_ack     (a_ack),
        .x_wr_en   (x_wr_en),
        .x_wr_addr (x_wr_addr),
        .x_wr_data (x_wr_data),
        // only watched by the unit's own check
        .busy      (),
        .dot_valid (dot_valid),
        .dot_value (dot_value),
        .dot_take  (dot_take)
    );

    sgd_label_buffer sgd_label_buffer_inst (
        .clk       (clk),
        .rst_n_g   (rst_n_g),
        .b_req     (b_req),
        .b_label   (b_label),
        .b_ack     (b_ack),
        .lbl_valid (lbl_valid),
        .lbl_value (lbl_value),
        .lbl_take  (lbl_take)
    );

    //////////////////////////////
    // loss
    //////////////////////////////

    sgd_loss sgd_loss_inst (
        .clk        (clk),
        .rst_n_g    (rst_n_g),
        .step_shift (step_shift),
        .dot_valid  (dot_valid),
        .dot_value  (dot_value),
        .dot_take   (dot_take),
        .lbl_valid  (lbl_valid),
        .lbl_value  (lbl_value),
        .lbl_take   (lbl_take),
        .res_req    (res_req),
        .res_error  (res_error),
        .res_ack    (res_ack)
    );

endmodule

//--- verif/sgd_tb.sv
// testbench for the loss front end, random samples checked against a reference model
`include "sgd_params.svh"

module sgd_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import sgd_pkg::*;

    localparam int HS_LIMIT    = 200;
    localparam int DRAIN_LIMIT = 2000;
    localparam int IDLE_LIMIT  = 10000;

    logic        clk;
    logic        rst_n_g;
    logic        a_req;
    plane_t      a_plane;
    logic        a_ack;
    logic        b_req;
    acc_t        b_label;
    logic        b_ack;
    logic        x_wr_en;
    feat_idx_t   x_wr_addr;
    model_word_t x_wr_data;
    shift_t      step_shift;
    logic        res_req;
    acc_t        res_error;
    logic        res_ack;

    // reference model state
    logic signed [`SGD_MODEL_WIDTH-1:0] x_model [`SGD_NUM_FEATURES];
    int cur_shift;
    // features packed 4 bits each with feature j at [4j+3:4j]
    logic [31:0] sample_q [$];
    logic [31:0] label_q [$];
    int exp_q [$];

    int sent_count;
    int res_count;
    int labels_acked;
    int value_errs;
    int proto_errs;
    int timeouts;
    logic [31:0] gen_lfsr;
    logic [31:0] dly_lfsr;
    event end_run;

    sgd_bw_loss_top sgd_bw_loss_top_inst (
        .clk        (clk),
        .rst_n_g    (rst_n_g),
        .a_req      (a_req),
        .a_plane    (a_plane),
        .a_ack      (a_ack),
        .b_req      (b_req),
        .b_label    (b_label),
        .b_ack      (b_ack),
        .x_wr_en    (x_wr_en),
        .x_wr_addr  (x_wr_addr),
        .x_wr_data  (x_wr_data),
        .step_shift (step_shift),
        .res_req    (res_req),
        .res_error  (res_error),
        .res_ack    (res_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // random numbers and model
    //////////////////////////////

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one step per bit taken
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            state = lfsr_step(state);
            v = {v[30:0], state[0]};
        end
    endtask

    // sum of x_j * f_j minus b then arithmetic shift
    function automatic int expected_error(input logic [31:0] feats, input int label,
                                          input int shift);
        int dot;
        int xv;
        int fv;
        dot = 0;
        for (int j = 0; j < `SGD_NUM_FEATURES; j++)
        begin
            xv = x_model[j];
            fv = feats[j*`SGD_FEATURE_BITS +: `SGD_FEATURE_BITS];
            dot = dot + xv * fv;
        end
        return (dot - label) >>> shift;
    endfunction

    // bit b of every feature
    function automatic plane_t plane_of(input logic [31:0] feats, input int b);
        plane_t p;
        for (int j = 0; j < `SGD_NUM_FEATURES; j++)
            p[j] = feats[j*`SGD_FEATURE_BITS + b];
        return p;
    endfunction

    task automatic raise_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: no %s", $time, what);
        -> end_run;
    endtask

    //////////////////////////////
    // sequence helpers
    //////////////////////////////

    task automatic write_model();
        logic [31:0] r;
        for (int j = 0; j < `SGD_NUM_FEATURES; j++)
        begin
            take_bits(gen_lfsr, 16, r);
            x_model[j] = r[15:0];
            @(posedge clk);
            x_wr_en   <= 1'b1;
            x_wr_addr <= feat_idx_t'(j);
            x_wr_data <= r[15:0];
        end
        @(posedge clk);
        x_wr_en <= 1'b0;
    endtask

    task automatic set_shift(input logic [4:0] s);
        @(posedge clk);
        step_shift <= s;
        cur_shift = s;
    endtask

    // labels sign extended from 24 bits so both signs of error show up
    task automatic make_sample(output logic [31:0] f, output logic [31:0] l);
        logic [31:0] r;
        take_bits(gen_lfsr, 32, f);
        take_bits(gen_lfsr, 24, r);
        l = {{8{r[23]}}, r[23:0]};
    endtask

    task automatic queue_samples(input int n);
        logic [31:0] f;
        logic [31:0] l;
        for (int i = 0; i < n; i++)
        begin
            make_sample(f, l);
            exp_q.push_back(expected_error(f, l, cur_shift));
            label_q.push_back(l);
            sample_q.push_back(f);
            sent_count++;
        end
    endtask

    // all results in and the result handshake back at rest
    task automatic drain();
        int t;
        t = 0;
        @(negedge clk);
        while (res_count != sent_count || res_req || res_ack)
        begin
            if (t == DRAIN_LIMIT)
            begin
                raise_timeout("drain of outstanding results");
                break;
            end
            @(negedge clk);
            t++;
        end
    endtask

    task automatic send_plane(input plane_t p);
        int t;
        @(posedge clk);
        a_plane <= p;
        a_req   <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!a_ack)
        begin
            if (t == HS_LIMIT)
            begin
                raise_timeout("rise of a_ack");
                break;
            end
            @(negedge clk);
            t++;
        end
        @(posedge clk);
        a_req <= 1'b0;
        t = 0;
        @(negedge clk);
        while (a_ack)
        begin
            if (t == HS_LIMIT)
            begin
                raise_timeout("fall of a_ack");
                break;
            end
            @(negedge clk);
            t++;
        end
    endtask

    task automatic send_label(input acc_t l);
        int t;
        @(posedge clk);
        b_label <= l;
        b_req   <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!b_ack)
        begin
            if (t == HS_LIMIT)
            begin
                raise_timeout("rise of b_ack");
                break;
            end
            @(negedge clk);
            t++;
        end
        labels_acked++;
        @(posedge clk);
        b_req <= 1'b0;
        t = 0;
        @(negedge clk);
        while (b_ack)
        begin
            if (t == HS_LIMIT)
            begin
                raise_timeout("fall of b_ack");
                break;
            end
            @(negedge clk);
            t++;
        end
    endtask

    //////////////////////////////
    // senders and receiver
    //////////////////////////////

    // msb plane first
    initial
    begin : plane_sender
        logic [31:0] feats;
        int idle;
        a_req   = 1'b0;
        a_plane = '0;
        idle    = 0;
        forever
        begin
            @(negedge clk);
            if (sample_q.size() == 0)
            begin
                idle++;
                if (idle == IDLE_LIMIT)
                    raise_timeout("sample to send");
            end
            else
            begin
                idle  = 0;
                feats = sample_q.pop_front();
                for (int k = `SGD_FEATURE_BITS - 1; k >= 0; k--)
                    send_plane(plane_of(feats, k));
            end
        end
    end

    initial
    begin : label_sender
        int idle;
        b_req   = 1'b0;
        b_label = '0;
        idle    = 0;
        forever
        begin
            @(negedge clk);
            if (label_q.size() == 0)
            begin
                idle++;
                if (idle == IDLE_LIMIT)
                    raise_timeout("label to send");
            end
            else
            begin
                idle = 0;
                send_label(label_q.pop_front());
            end
        end
    end

    // random delay before raising and before dropping res_ack
    initial
    begin : result_receiver
        logic [31:0] r;
        acc_t held;
        int exp_v;
        int t;
        int idle;
        res_ack = 1'b0;
        idle    = 0;
        forever
        begin
            @(negedge clk);
            if (!res_req)
            begin
                idle++;
                if (idle == IDLE_LIMIT)
                    raise_timeout("result from the DUT");
            end
            else
            begin
                idle = 0;
                held = res_error;
                res_count++;
                if (exp_q.size() == 0)
                begin
                    proto_errs++;
                    $display("result %0d at %0t with no sample outstanding", held, $time);
                end
                else
                begin
                    exp_v = exp_q.pop_front();
                    if (held !== exp_v)
                    begin
                        value_errs++;
                        $display("** Error at %0t: res_error expected %0d, got %0d",
                                 $time, exp_v, held);
                    end
                end
                // error must hold while req waits for ack
                take_bits(dly_lfsr, 2, r);
                repeat (r[1:0])
                begin
                    @(negedge clk);
                    if (!res_req)
                    begin
                        proto_errs++;
                        $display("res_req dropped before res_ack at %0t", $time);
                    end
                    if (res_error !== held)
                    begin
                        value_errs++;
                        $display("** Error at %0t: res_error expected %0d, got %0d",
                                 $time, held, res_error);
                    end
                end
                @(posedge clk);
                res_ack <= 1'b1;
                t = 0;
                @(negedge clk);
                while (res_req)
                begin
                    if (t == HS_LIMIT)
                    begin
                        raise_timeout("fall of res_req");
                        break;
                    end
                    @(negedge clk);
                    t++;
                end
                take_bits(dly_lfsr, 2, r);
                repeat (r[1:0]) @(posedge clk);
                @(posedge clk);
                res_ack <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin : main_seq
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] l;
        logic [31:0] held_feats [$];
        int base;
        int t;
        gen_lfsr   = 32'ha0c0;
        dly_lfsr   = 32'ha0c0;
        sent_count = 0;
        res_count  = 0;
        labels_acked = 0;
        value_errs = 0;
        proto_errs = 0;
        timeouts   = 0;
        cur_shift  = 0;
        rst_n_g    = 1'b0;
        x_wr_en    = 1'b0;
        x_wr_addr  = '0;
        x_wr_data  = '0;
        step_shift = '0;
        repeat (10) @(posedge clk);
        rst_n_g <= 1'b1;

        // no requests, so no acks and no results
        repeat (20)
        begin
            @(negedge clk);
            if (a_ack || b_ack || res_req)
            begin
                proto_errs++;
                $display("handshake output high after reset with no request at %0t", $time);
            end
        end

        // plain difference
        write_model();
        set_shift(5'd0);
        queue_samples(12);
        drain();

        // shift changed only between batches
        repeat (4)
        begin
            take_bits(gen_lfsr, 5, r);
            set_shift(r[4:0]);
            queue_samples(6);
            drain();
        end

        // fresh model words
        write_model();
        take_bits(gen_lfsr, 5, r);
        set_shift(r[4:0]);
        queue_samples(6);
        drain();

        // six labels ahead of any sample
        take_bits(gen_lfsr, 5, r);
        set_shift(r[4:0]);
        base = labels_acked;
        for (int i = 0; i < 6; i++)
        begin
            make_sample(f, l);
            exp_q.push_back(expected_error(f, l, cur_shift));
            label_q.push_back(l);
            held_feats.push_back(f);
            sent_count++;
        end
        t = 0;
        @(negedge clk);
        while (labels_acked - base < `SGD_LABEL_FIFO_DEPTH)
        begin
            if (t == HS_LIMIT)
            begin
                raise_timeout("fill of the label fifo");
                break;
            end
            @(negedge clk);
            t++;
        end
        // let the fourth label handshake settle
        repeat (5) @(negedge clk);
        repeat (20)
        begin
            @(negedge clk);
            if (b_ack || labels_acked - base != `SGD_LABEL_FIFO_DEPTH)
            begin
                proto_errs++;
                $display("label acknowledged while the label fifo is full at %0t", $time);
            end
        end
        while (held_feats.size() != 0)
            sample_q.push_back(held_feats.pop_front());
        drain();

        // nothing extra comes out
        repeat (10)
        begin
            @(negedge clk);
            if (res_req)
            begin
                proto_errs++;
                $display("extra result after the last sample at %0t", $time);
            end
        end
        -> end_run;
    end

    initial
    begin : report
        @(end_run);
        $display("%0d results, %0d value errors, %0d protocol errors, %0d timeouts",
                 res_count, value_errs, proto_errs, timeouts);
        if (value_errs == 0 && proto_errs == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/sgd_pkg.sv
hdl/sgd_dot_product.sv
hdl/sgd_label_buffer.sv
hdl/sgd_loss.sv
hdl/sgd_bw_loss_top.sv
verif/sgd_tb.sv

//--- Bender.yml
package:
  name: sgd_bw_loss

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sgd_pkg.sv
      - hdl/sgd_dot_product.sv
      - hdl/sgd_label_buffer.sv
      - hdl/sgd_loss.sv
      - hdl/sgd_bw_loss_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/sgd_tb.sv
